/* verilog.f */
verilog/cam_bist_pkg.sv
verilog/cam_bist_ctrl.sv
verilog/cam_bist_addr_cnt.sv
verilog/cam_bist_inhandler.sv
verilog/cam_bist_match_chk.sv
verilog/cam_bist_top.sv
testbench/tb_clk_gen.sv
testbench/tb_cam_model.sv
testbench/tb_cam_bist.sv

/* Bender.yml */
package:
  name: cam_bist

sources:
  - verilog/cam_bist_pkg.sv
  - verilog/cam_bist_ctrl.sv
  - verilog/cam_bist_addr_cnt.sv
  - verilog/cam_bist_inhandler.sv
  - verilog/cam_bist_match_chk.sv
  - verilog/cam_bist_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_cam_model.sv
      - testbench/tb_cam_bist.sv

/* testbench/tb_cam_bist.sv */
/*
 * CAM BIST testbench
 * Runs the BIST four times against the behavioral CAM: clean, with
 * a random stuck bit, clean again and with a second stuck bit. Every
 * write and search on the CAM port is checked as it happens, and each
 * run's fail summary is checked against a software replay.
 */

`timescale 1ns/1ps

module tb_cam_bist;

   // Search index where each pass begins
   localparam int MSRCH_BASE = cam_bist_pkg::CAM_DEPTH;
   localparam int SRCH1_BASE = MSRCH_BASE + cam_bist_pkg::CAM_DEPTH * cam_bist_pkg::CAM_WIDTH;
   localparam int N_SRCH     = SRCH1_BASE + cam_bist_pkg::CAM_DEPTH;
   localparam int N_WR       = 2 * cam_bist_pkg::CAM_DEPTH;
   // About 324 cycles per run plus gaps
   localparam int RUN_CYCLES = 330;
   localparam int N_RUNS     = 4;
   localparam int TIMEOUT    = N_RUNS * RUN_CYCLES + 200;
   localparam int SEED       = 29554;

   typedef struct packed {
      cam_bist_pkg::fail_cnt_t count;
      cam_bist_pkg::cam_addr_t first;
   } bist_result_t;

   logic                              bist_clk;
   logic                              rst_b;
   logic                              bist_start;
   cam_bist_pkg::cam_req_t            cam_req;
   cam_bist_pkg::cam_match_t          cam_match;
   logic                              bist_done;
   logic                              bist_fail;
   cam_bist_pkg::fail_cnt_t           fail_count;
   cam_bist_pkg::cam_addr_t           first_fail_addr;
   logic                              fault_en;
   cam_bist_pkg::cam_addr_t           fault_entry;
   logic [cam_bist_pkg::BITPOS_W-1:0] fault_bit;
   logic                              fault_val;

   // Port activity seen in the current run
   int                                wr_idx;
   int                                srch_idx;
   int                                rule_miss;
   logic                              reply_pend;
   cam_bist_pkg::cam_match_t          exp_reply;
   cam_bist_pkg::cam_data_t           exp_word;
   int                                mismatch_errs;
   int                                other_errs;
   int                                cycle_cnt;
   bist_result_t                      exp_res;

   tb_clk_gen clk_gen_i (
      .bist_clk (bist_clk),
      .rst_b    (rst_b)
   );

   cam_bist_top cam_bist_top_i (
      .bist_clk        (bist_clk),
      .rst_b           (rst_b),
      .bist_start      (bist_start),
      .cam_match       (cam_match),
      .cam_req         (cam_req),
      .bist_done       (bist_done),
      .bist_fail       (bist_fail),
      .fail_count      (fail_count),
      .first_fail_addr (first_fail_addr)
   );

   tb_cam_model cam_model_i (
      .bist_clk    (bist_clk),
      .cam_req     (cam_req),
      .fault_en    (fault_en),
      .fault_entry (fault_entry),
      .fault_bit   (fault_bit),
      .fault_val   (fault_val),
      .cam_match   (cam_match)
   );

   // ------------------------------
   // Pattern rules
   // ------------------------------

   // Background tagged with the address and flipped whole when inverted
   function automatic cam_bist_pkg::cam_data_t pattern_word(input int a, input logic inv);
      cam_bist_pkg::cam_data_t word;
      word = cam_bist_pkg::BIST_BACKGROUND ^ cam_bist_pkg::cam_data_t'(a);
      if (inv) begin
         word = ~word;
      end
      return word;
   endfunction

   // Compare data of the n-th search of a run
   function automatic cam_bist_pkg::cam_data_t search_word(input int idx);
      int a;
      int sweep;
      a = idx % cam_bist_pkg::CAM_DEPTH;
      if (idx < MSRCH_BASE) begin
         return pattern_word(a, 1'b0);
      end else if (idx < SRCH1_BASE) begin
         // One mask bit per sweep starting at bit 0
         sweep = (idx - MSRCH_BASE) / cam_bist_pkg::CAM_DEPTH;
         return pattern_word(a, 1'b0) ^ (cam_bist_pkg::cam_data_t'(1) << sweep);
      end
      return pattern_word(a, 1'b1);
   endfunction

   // Clean upper bits mean a single hit at the tag and anything else no hit
   function automatic cam_bist_pkg::cam_match_t rule_match(
         input cam_bist_pkg::cam_data_t word, input logic inv);
      cam_bist_pkg::cam_data_t key;
      key = word ^ cam_bist_pkg::BIST_BACKGROUND;
      if (inv) begin
         key = ~key;
      end
      if (key[cam_bist_pkg::CAM_WIDTH-1:cam_bist_pkg::ADDR_W] == '0) begin
         return cam_bist_pkg::cam_match_t'(1) << key[cam_bist_pkg::ADDR_W-1:0];
      end
      return '0;
   endfunction

   // ------------------------------
   // Reference replay
   // ------------------------------
   function automatic bist_result_t ref_bist_result(input logic f_en,
         input cam_bist_pkg::cam_addr_t f_entry,
         input logic [cam_bist_pkg::BITPOS_W-1:0] f_bit, input logic f_val);
      cam_bist_pkg::cam_data_t  mem [cam_bist_pkg::CAM_DEPTH];
      cam_bist_pkg::cam_data_t  word;
      cam_bist_pkg::cam_match_t reply;
      bist_result_t             res;
      logic                     found;
      int                       pass;
      int                       a;
      int                       i;
      res   = '0;
      found = 1'b0;
      for (pass = 0; pass < 2; pass++) begin
         // Write pass with the stuck cell applied as in the model
         for (a = 0; a < cam_bist_pkg::CAM_DEPTH; a++) begin
            word = pattern_word(a, pass == 1);
            if (f_en && (a == f_entry)) begin
               word[f_bit] = f_val;
            end
            mem[a] = word;
         end
         // Plain and masked searches follow the first writes and inverted ones the second
         for (i = (pass == 0) ? 0 : SRCH1_BASE; i < ((pass == 0) ? SRCH1_BASE : N_SRCH); i++) begin
            word = search_word(i);
            for (a = 0; a < cam_bist_pkg::CAM_DEPTH; a++) begin
               reply[a] = (mem[a] == word);
            end
            if (reply != rule_match(word, i >= SRCH1_BASE)) begin
               if (res.count != '1) begin
                  res.count++;
               end
               if (!found) begin
                  res.first = cam_bist_pkg::cam_addr_t'(i % cam_bist_pkg::CAM_DEPTH);
                  found     = 1'b1;
               end
            end
         end
      end
      return res;
   endfunction

   // ------------------------------
   // Reporting
   // ------------------------------
   task automatic report_mismatch(input string name, input logic [31:0] got,
         input logic [31:0] exp);
      mismatch_errs++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
   endtask

   task automatic report_error(input string msg);
      other_errs++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   // ------------------------------
   // Port monitor and compare
   // ------------------------------
   always @(negedge bist_clk) begin
      if (rst_b) begin
         // Reply to last cycle's search
         if (reply_pend) begin
            if (!fault_en) begin
               if (cam_match !== exp_reply) begin
                  report_mismatch("cam_match", cam_match, exp_reply);
               end
            end else if (cam_match != exp_reply) begin
               rule_miss++;
            end
         end
         reply_pend = 1'b0;
         if (cam_req.wr_en) begin
            if (wr_idx >= N_WR) begin
               report_error("write request beyond the two write passes");
            end else begin
               exp_word = pattern_word(wr_idx % cam_bist_pkg::CAM_DEPTH,
                                       wr_idx >= cam_bist_pkg::CAM_DEPTH);
               if (cam_req.addr !== cam_bist_pkg::cam_addr_t'(wr_idx)) begin
                  report_mismatch("cam_req.addr", cam_req.addr, wr_idx[3:0]);
               end
               if (cam_req.wr_data !== exp_word) begin
                  report_mismatch("cam_req.wr_data", cam_req.wr_data, exp_word);
               end
            end
            wr_idx++;
         end
         if (cam_req.srch_en) begin
            if (srch_idx >= N_SRCH) begin
               report_error("search request beyond the three search passes");
            end else begin
               exp_word = search_word(srch_idx);
               if (cam_req.addr !== cam_bist_pkg::cam_addr_t'(srch_idx)) begin
                  report_mismatch("cam_req.addr", cam_req.addr, srch_idx[3:0]);
               end
               if (cam_req.srch_data !== exp_word) begin
                  report_mismatch("cam_req.srch_data", cam_req.srch_data, exp_word);
               end
               exp_reply  = rule_match(exp_word, srch_idx >= SRCH1_BASE);
               reply_pend = 1'b1;
            end
            srch_idx++;
         end
      end
   end

   // Hard stop if a run never finishes
   always @(posedge bist_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT) begin
         $display("Timeout: BIST runs did not finish within %0d cycles", TIMEOUT);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   // ------------------------------
   // Run control
   // ------------------------------
   task automatic start_run(input logic f_en, input cam_bist_pkg::cam_addr_t f_entry,
         input logic [cam_bist_pkg::BITPOS_W-1:0] f_bit, input logic f_val);
      @(posedge bist_clk);
      fault_en    <= f_en;
      fault_entry <= f_entry;
      fault_bit   <= f_bit;
      fault_val   <= f_val;
      bist_start  <= 1'b1;
      wr_idx    = 0;
      srch_idx  = 0;
      rule_miss = 0;
      @(posedge bist_clk);
      bist_start <= 1'b0;
   endtask

   task automatic finish_run(input bist_result_t exp);
      do begin
         @(negedge bist_clk);
      end while (!bist_done);
      if (bist_fail !== (exp.count != 0)) begin
         report_mismatch("bist_fail", bist_fail, exp.count != 0);
      end
      if (fail_count !== exp.count) begin
         report_mismatch("fail_count", fail_count, exp.count);
      end
      if (first_fail_addr !== exp.first) begin
         report_mismatch("first_fail_addr", first_fail_addr, exp.first);
      end
      if (fault_en && (rule_miss != exp.count)) begin
         report_mismatch("failing replies", rule_miss, exp.count);
      end
      if (wr_idx != N_WR) begin
         report_error($sformatf("run issued %0d writes instead of %0d", wr_idx, N_WR));
      end
      if (srch_idx != N_SRCH) begin
         report_error($sformatf("run issued %0d searches instead of %0d", srch_idx, N_SRCH));
      end
      // Done is a single-cycle pulse
      @(negedge bist_clk);
      if (bist_done !== 1'b0) begin
         report_error("bist_done stayed high for more than one cycle");
      end
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      void'($urandom(SEED));
      bist_start    = 1'b0;
      fault_en      = 1'b0;
      fault_entry   = '0;
      fault_bit     = '0;
      fault_val     = 1'b0;
      wr_idx        = 0;
      srch_idx      = 0;
      rule_miss     = 0;
      reply_pend    = 1'b0;
      exp_reply     = '0;
      mismatch_errs = 0;
      other_errs    = 0;
      cycle_cnt     = 0;

      @(posedge rst_b);
      @(negedge bist_clk);
      if (cam_req.wr_en !== 1'b0 || cam_req.srch_en !== 1'b0) begin
         report_error("CAM port enables not low after reset");
      end
      if (bist_done !== 1'b0 || bist_fail !== 1'b0 || fail_count !== '0) begin
         report_error("done, fail or fail count not clear after reset");
      end

      // Clean run with a stray start in the middle
      start_run(1'b0, '0, '0, 1'b0);
      repeat (40) @(posedge bist_clk);
      bist_start <= 1'b1;
      @(posedge bist_clk);
      bist_start <= 1'b0;
      finish_run(ref_bist_result(1'b0, '0, '0, 1'b0));

      // Two faulty runs around a clean one
      for (int run = 0; run < 3; run++) begin
         if (run == 1) begin
            start_run(1'b0, '0, '0, 1'b0);
            finish_run(ref_bist_result(1'b0, '0, '0, 1'b0));
         end else begin
            fault_entry = cam_bist_pkg::cam_addr_t'($urandom % cam_bist_pkg::CAM_DEPTH);
            fault_bit   = ($urandom % cam_bist_pkg::CAM_WIDTH);
            fault_val   = $urandom % 2;
            $display("Stuck-at-%0d on entry %0d bit %0d", fault_val, fault_entry, fault_bit);
            exp_res = ref_bist_result(1'b1, fault_entry, fault_bit, fault_val);
            start_run(1'b1, fault_entry, fault_bit, fault_val);
            finish_run(exp_res);
         end
      end

      $display("Summary: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
      if (mismatch_errs == 0 && other_errs == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* testbench/tb_cam_model.sv */
/*
 * Behavioral CAM model
 * 16x16 storage with one write/search port and a registered match
 * vector one cycle after each search. One stored bit can be held
 * stuck at a chosen value to model a cell fault.
 */

`timescale 1ns/1ps

module tb_cam_model (
   input  logic                                  bist_clk,
   input  cam_bist_pkg::cam_req_t                cam_req,
   input  logic                                  fault_en,
   input  cam_bist_pkg::cam_addr_t               fault_entry,
   input  logic [cam_bist_pkg::BITPOS_W-1:0]     fault_bit,
   input  logic                                  fault_val,
   output cam_bist_pkg::cam_match_t              cam_match
);

   cam_bist_pkg::cam_data_t mem [cam_bist_pkg::CAM_DEPTH];
   cam_bist_pkg::cam_data_t store_word;

   // Power-up contents, a different word in every entry
   initial begin
      for (int a = 0; a < cam_bist_pkg::CAM_DEPTH; a++) begin
         mem[a] = {4{a[3:0]}} ^ 16'h3C3C;
      end
   end

   // Stuck cell overrides one bit of the faulty entry
   always_comb begin
      store_word = cam_req.wr_data;
      if (fault_en && (cam_req.addr == fault_entry)) begin
         store_word[fault_bit] = fault_val;
      end
   end

   always @(posedge bist_clk) begin
      if (cam_req.wr_en) begin
         mem[cam_req.addr] <= store_word;
      end
      // Reply is all zeros on cycles without a search
      for (int e = 0; e < cam_bist_pkg::CAM_DEPTH; e++) begin
         cam_match[e] <= cam_req.srch_en && (mem[e] == cam_req.srch_data);
      end
   end

endmodule

/* testbench/tb_clk_gen.sv */
/*
 * Testbench clock and reset
 * Free-running 100 ns clock, reset held low for the first 3 cycles
 */

`timescale 1ns/1ps

module tb_clk_gen (
   output logic bist_clk,
   output logic rst_b
);

   localparam int HALF_PERIOD = 50;

   initial begin
      bist_clk = 1'b0;
      forever #(HALF_PERIOD) bist_clk = ~bist_clk;
   end

   // Released on the third rising edge
   initial begin
      rst_b = 1'b0;
      repeat (3) @(posedge bist_clk);
      rst_b <= 1'b1;
   end

endmodule

/* verilog/cam_bist_top.sv */
/*
 * CAM BIST top
 * Ties the controller, counters, input handler and checker together
 * and registers the request once before it goes to the CAM port.
 */

`timescale 1ns/1ps

module cam_bist_top (
   input  logic                    bist_clk,
   input  logic                    rst_b,
   input  logic                    bist_start,
   input  cam_bist_pkg::cam_match_t cam_match,
   output cam_bist_pkg::cam_req_t   cam_req,
   output logic                    bist_done,
   output logic                    bist_fail,
   output cam_bist_pkg::fail_cnt_t  fail_count,
   output cam_bist_pkg::cam_addr_t  first_fail_addr
);

   cam_bist_pkg::bist_ctl_t ctl;
   cam_bist_pkg::cam_req_t  req_next;
   logic                    addr_inc;
   logic                    bit_inc;
   logic                    addr_last;
   logic                    bit_last;

   cam_bist_ctrl ctrl_i (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .bist_start (bist_start),
      .addr_last  (addr_last),
      .bit_last   (bit_last),
      .ctl        (ctl),
      .wr_en      (req_next.wr_en),
      .srch_en    (req_next.srch_en),
      .addr_inc   (addr_inc),
      .bit_inc    (bit_inc),
      .done       (bist_done)
   );

   cam_bist_addr_cnt addr_cnt_i (
      .bist_clk  (bist_clk),
      .rst_b     (rst_b),
      .addr_inc  (addr_inc),
      .bit_inc   (bit_inc),
      .addr      (req_next.addr),
      .addr_last (addr_last),
      .bit_last  (bit_last)
   );

   cam_bist_inhandler inhandler_i (
      .bist_clk  (bist_clk),
      .rst_b     (rst_b),
      .ctl       (ctl),
      .addr      (req_next.addr),
      .wr_data   (req_next.wr_data),
      .srch_data (req_next.srch_data)
   );

   // Checker sees the unregistered search, its delay covers the output flop
   cam_bist_match_chk match_chk_i (
      .bist_clk        (bist_clk),
      .rst_b           (rst_b),
      .srch_en         (req_next.srch_en),
      .data_inv        (ctl.data_inv),
      .srch_data       (req_next.srch_data),
      .srch_addr       (req_next.addr),
      .cam_match       (cam_match),
      .clear           (bist_start),
      .fail            (bist_fail),
      .fail_count      (fail_count),
      .first_fail_addr (first_fail_addr)
   );

   // ------------------------------
   // CAM request register
   // ------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         cam_req.wr_en   <= 1'b0;
         cam_req.srch_en <= 1'b0;
      end else begin
         cam_req.wr_en   <= req_next.wr_en;
         cam_req.srch_en <= req_next.srch_en;
      end
   end

   // Address and data fields
   always_ff @(posedge bist_clk) begin
      cam_req.addr      <= req_next.addr;
      cam_req.wr_data   <= req_next.wr_data;
      cam_req.srch_data <= req_next.srch_data;
   end

endmodule

/* verilog/cam_bist_match_chk.sv */
/*
 * CAM BIST match checker
 * Delays each search by two cycles to line up with the CAM reply,
 * decodes the expected match vector from the compare data, and counts
 * mismatches. Keeps a sticky fail flag and the first failing address.
 */

`timescale 1ns/1ps

module cam_bist_match_chk (
   input  logic                    bist_clk,
   input  logic                    rst_b,
   input  logic                    srch_en,
   input  logic                    data_inv,
   input  cam_bist_pkg::cam_data_t  srch_data,
   input  cam_bist_pkg::cam_addr_t  srch_addr,
   input  cam_bist_pkg::cam_match_t cam_match,
   input  logic                    clear,
   output logic                    fail,
   output cam_bist_pkg::fail_cnt_t  fail_count,
   output cam_bist_pkg::cam_addr_t  first_fail_addr
);

   // Search fields carried down the delay line
   typedef struct packed {
      logic                   data_inv;
      cam_bist_pkg::cam_data_t srch_data;
      cam_bist_pkg::cam_addr_t srch_addr;
   } srch_info_t;

   logic [1:0]                 vld_d;
   srch_info_t                 info_d1;
   srch_info_t                 info_d2;
   cam_bist_pkg::cam_data_t    key;
   cam_bist_pkg::cam_match_t   exp_match;
   logic                       mismatch;

   // ------------------------------
   // Two-cycle delay line
   // ------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         vld_d <= '0;
      end else begin
         vld_d <= {vld_d[0], srch_en};
      end
   end

   always_ff @(posedge bist_clk) begin
      info_d1 <= '{data_inv: data_inv, srch_data: srch_data, srch_addr: srch_addr};
      info_d2 <= info_d1;
   end

   // ------------------------------
   // Expected vector
   // ------------------------------

   // Strip background and inversion, leaving the tag and any mask flip
   assign key = info_d2.srch_data ^ cam_bist_pkg::BIST_BACKGROUND
                ^ {cam_bist_pkg::CAM_WIDTH{info_d2.data_inv}};

   // Upper bits clean means exactly the tagged entry hits
   assign exp_match = (key[cam_bist_pkg::CAM_WIDTH-1:cam_bist_pkg::ADDR_W] == '0)
                      ? cam_bist_pkg::cam_match_t'(1) << key[cam_bist_pkg::ADDR_W-1:0]
                      : '0;

   assign mismatch = vld_d[1] && (cam_match != exp_match);

   // ------------------------------
   // Fail tracking
   // ------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b || clear) begin
         fail            <= 1'b0;
         fail_count      <= '0;
         first_fail_addr <= '0;
      end else if (mismatch) begin
         fail <= 1'b1;
         // Saturate at all ones
         if (fail_count != '1) begin
            fail_count <= fail_count + 1'b1;
         end
         if (!fail) begin
            first_fail_addr <= info_d2.srch_addr;
         end
      end
   end

endmodule

/* verilog/cam_bist_inhandler.sv */
/*
 * CAM BIST input handler
 * Holds the rotating one-hot mask, builds the address-tagged write
 * pattern with optional inversion, and muxes the compare data onto the
 * search bus, masked or plain.
 */

`timescale 1ns/1ps

module cam_bist_inhandler (
   input  logic                   bist_clk,
   input  logic                   rst_b,
   input  cam_bist_pkg::bist_ctl_t ctl,
   input  cam_bist_pkg::cam_addr_t addr,
   output cam_bist_pkg::cam_data_t wr_data,
   output cam_bist_pkg::cam_data_t srch_data
);

   cam_bist_pkg::cam_data_t mask;
   cam_bist_pkg::cam_data_t pattern;
   cam_bist_pkg::cam_data_t cmp_data;

   // ------------------------------
   // Rotating mask
   // ------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         // Walk starts at bit 0
         mask <= cam_bist_pkg::cam_data_t'(1);
      end else if (ctl.rotate_mask) begin
         // Left rotate, MSB wraps to bit 0
         mask <= {mask[cam_bist_pkg::CAM_WIDTH-2:0], mask[cam_bist_pkg::CAM_WIDTH-1]};
      end
   end

   // ------------------------------
   // Write pattern
   // ------------------------------

   // Background with the entry address in the low nibble
   assign pattern = cam_bist_pkg::BIST_BACKGROUND ^ cam_bist_pkg::cam_data_t'(addr);

   // Whole word flips on the inverted passes
   assign wr_data = pattern ^ {cam_bist_pkg::CAM_WIDTH{ctl.data_inv}};

   // ------------------------------
   // Compare data
   // ------------------------------

   // Masked bit is flipped only during the walking-mask pass
   assign cmp_data = wr_data ^ (mask & {cam_bist_pkg::CAM_WIDTH{ctl.cd_mask_en}});

   // Search bus held at zero outside search cycles
   assign srch_data = ctl.cm_mode ? cmp_data : '0;

endmodule

/* verilog/cam_bist_addr_cnt.sv */
/*
 * CAM BIST address counter
 * Entry address counter and mask position counter. Both wrap to zero
 * and flag their final value, so each pass starts at entry 0.
 */

`timescale 1ns/1ps

module cam_bist_addr_cnt (
   input  logic                   bist_clk,
   input  logic                   rst_b,
   input  logic                   addr_inc,
   input  logic                   bit_inc,
   output cam_bist_pkg::cam_addr_t addr,
   output logic                   addr_last,
   output logic                   bit_last
);

   // Mask position, one step per MSRCH sweep
   logic [cam_bist_pkg::BITPOS_W-1:0] bit_pos;

   // ------------------------------
   // Entry address
   // ------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         addr <= '0;
      end else if (addr_inc) begin
         // Natural wrap at CAM_DEPTH
         addr <= addr + 1'b1;
      end
   end

   // ------------------------------
   // Mask position
   // ------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         bit_pos <= '0;
      end else if (bit_inc) begin
         bit_pos <= bit_pos + 1'b1;
      end
   end

   // Final values
   assign addr_last = (addr == cam_bist_pkg::cam_addr_t'(cam_bist_pkg::CAM_DEPTH - 1));
   assign bit_last  = (bit_pos == (cam_bist_pkg::BITPOS_W)'(cam_bist_pkg::CAM_WIDTH - 1));

endmodule

/* verilog/cam_bist_ctrl.sv */
/*
 * CAM BIST controller
 * Steps through the write, search, walking-mask search and inverted
 * passes, one entry per cycle. Drives the mode bits for the input
 * handler, the counter strobes and the port enables, then drains the
 * reply pipeline and pulses done.
 */

`timescale 1ns/1ps

module cam_bist_ctrl (
   input  logic                   bist_clk,
   input  logic                   rst_b,
   input  logic                   bist_start,
   input  logic                   addr_last,
   input  logic                   bit_last,
   output cam_bist_pkg::bist_ctl_t ctl,
   output logic                   wr_en,
   output logic                   srch_en,
   output logic                   addr_inc,
   output logic                   bit_inc,
   output logic                   done
);

   cam_bist_pkg::bist_state_e state;
   cam_bist_pkg::bist_state_e state_next;
   // Counts the two drain cycles
   logic                      drain_cnt;

   // ------------------------------
   // State register
   // ------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state     <= cam_bist_pkg::IDLE;
         drain_cnt <= 1'b0;
      end else begin
         state <= state_next;
         // Toggles only while draining, so it is zero on entry
         drain_cnt <= (state == cam_bist_pkg::DRAIN) ? ~drain_cnt : 1'b0;
      end
   end

   // ------------------------------
   // Next state and outputs
   // ------------------------------
   always_comb begin
      state_next      = state;
      ctl             = '0;
      wr_en           = 1'b0;
      srch_en         = 1'b0;
      addr_inc        = 1'b0;
      bit_inc         = 1'b0;
      done            = 1'b0;

      case (state)
         cam_bist_pkg::IDLE: begin
            // Start is only looked at here
            if (bist_start) begin
               state_next = cam_bist_pkg::WR0;
            end
         end
         cam_bist_pkg::WR0: begin
            wr_en    = 1'b1;
            addr_inc = 1'b1;
            if (addr_last) begin
               state_next = cam_bist_pkg::SRCH0;
            end
         end
         cam_bist_pkg::SRCH0: begin
            srch_en     = 1'b1;
            addr_inc    = 1'b1;
            ctl.cm_mode = 1'b1;
            if (addr_last) begin
               state_next = cam_bist_pkg::MSRCH;
            end
         end
         cam_bist_pkg::MSRCH: begin
            srch_en        = 1'b1;
            addr_inc       = 1'b1;
            ctl.cm_mode    = 1'b1;
            ctl.cd_mask_en = 1'b1;
            // End of a sweep moves the mask to the next bit
            if (addr_last) begin
               ctl.rotate_mask = 1'b1;
               bit_inc         = 1'b1;
               if (bit_last) begin
                  state_next = cam_bist_pkg::WR1;
               end
            end
         end
         cam_bist_pkg::WR1: begin
            wr_en        = 1'b1;
            addr_inc     = 1'b1;
            ctl.data_inv = 1'b1;
            if (addr_last) begin
               state_next = cam_bist_pkg::SRCH1;
            end
         end
         cam_bist_pkg::SRCH1: begin
            srch_en      = 1'b1;
            addr_inc     = 1'b1;
            ctl.cm_mode  = 1'b1;
            ctl.data_inv = 1'b1;
            if (addr_last) begin
               state_next = cam_bist_pkg::DRAIN;
            end
         end
         cam_bist_pkg::DRAIN: begin
            // Last reply reaches the checker on the second cycle
            if (drain_cnt) begin
               state_next = cam_bist_pkg::DONE;
            end
         end
         cam_bist_pkg::DONE: begin
            done       = 1'b1;
            state_next = cam_bist_pkg::IDLE;
         end
         default: begin
            state_next = cam_bist_pkg::IDLE;
         end
      endcase
   end

endmodule

/* verilog/cam_bist_pkg.sv */
/*
 * CAM BIST shared definitions
 * Widths, background pattern and vector types for the 16x16 CAM,
 * the controller state encoding, and the structs that carry the
 * controller's mode bits and the request sent to the CAM port.
 */

package cam_bist_pkg;

   // ------------------------------
   // Geometry
   // ------------------------------

   // Entries in the CAM
   localparam int CAM_DEPTH = 16;
   // Data bits per entry
   localparam int CAM_WIDTH = 16;
   // Entry address width
   localparam int ADDR_W = 4;
   // Mask position width, one position per data bit
   localparam int BITPOS_W = $clog2(CAM_WIDTH);
   // Fail counter width
   localparam int FAIL_W = 8;

   // Background word, low nibble left clear for the entry address
   localparam logic [CAM_WIDTH-1:0] BIST_BACKGROUND = 16'hA5A0;

   // ------------------------------
   // Vector types
   // ------------------------------

   typedef logic [CAM_WIDTH-1:0] cam_data_t;
   typedef logic [ADDR_W-1:0]    cam_addr_t;
   // One bit per entry
   typedef logic [CAM_DEPTH-1:0] cam_match_t;
   typedef logic [FAIL_W-1:0]    fail_cnt_t;

   // Controller passes, in run order
   typedef enum logic [2:0] {
      IDLE,
      WR0,
      SRCH0,
      MSRCH,
      WR1,
      SRCH1,
      DRAIN,
      DONE
   } bist_state_e;

   // Mode bits from the controller to the input handler
   typedef struct packed {
      logic cm_mode;
      logic rotate_mask;
      logic cd_mask_en;
      logic data_inv;
   } bist_ctl_t;

   // One CAM port request
   typedef struct packed {
      logic      wr_en;
      logic      srch_en;
      cam_addr_t addr;
      cam_data_t wr_data;
      cam_data_t srch_data;
   } cam_req_t;

endpackage
